// ==== dv/mips_control_properties.sv ====
`timescale 1ns/1ps

module mips_control_properties (
    input logic clk,
    input logic reset,
    input logic pc_write,
    input logic ir_write,
    input logic a_write,
    input logic b_write,
    input logic alu_out_write,
    input logic reg_write,
    input logic epc_write
);

    logic [6:0] all_strobes;

    assign all_strobes = {pc_write, ir_write, a_write, b_write,
                          alu_out_write, reg_write, epc_write};

    // EPC commit always redirects the PC in the same cycle
    epc_with_pc: assert property (@(posedge clk) disable iff (reset) epc_write |-> pc_write)
        else $error("epc_write asserted without pc_write");

    no_reg_and_epc: assert property (@(posedge clk) disable iff (reset)
                                     !(reg_write && epc_write))
        else $error("reg_write and epc_write asserted together");

    quiet_after_reset: assert property (@(posedge clk) reset |=> (all_strobes == 7'b0))
        else $error("strobe active in the cycle after reset");

endmodule

bind mips_control mips_control_properties u_mips_control_properties (
    .clk           (clk),
    .reset         (reset),
    .pc_write      (pc_write),
    .ir_write      (ir_write),
    .a_write       (a_write),
    .b_write       (b_write),
    .alu_out_write (alu_out_write),
    .reg_write     (reg_write),
    .epc_write     (epc_write)
);

// ==== dv/control_model.svh ====
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// Reference state and the cycles already spent in it
ctrl_pkg::ctrl_state_t model_state;
int                    model_cycles;
int                    alu_count;
int                    load_count;
int                    ovf_count;
int                    illegal_count;

function automatic void model_reset();
    model_state   = ctrl_pkg::ST_FETCH_WAIT;
    model_cycles  = 0;
    alu_count     = 0;
    load_count    = 0;
    ovf_count     = 0;
    illegal_count = 0;
endfunction

// Execute state chosen by an instruction, straight from the opcode map
function automatic ctrl_pkg::ctrl_state_t execute_state(logic [5:0] op, logic [5:0] fn);
    case (op)
        6'h00: begin
            case (fn)
                6'h20:   return ctrl_pkg::ST_ADD;
                6'h24:   return ctrl_pkg::ST_AND;
                6'h22:   return ctrl_pkg::ST_SUB;
                default: return ctrl_pkg::ST_EXC_NOOPCODE;
            endcase
        end
        6'h08:   return ctrl_pkg::ST_ADDI;
        6'h09:   return ctrl_pkg::ST_ADDIU;
        6'h23:   return ctrl_pkg::ST_LW;
        6'h21:   return ctrl_pkg::ST_LH;
        6'h20:   return ctrl_pkg::ST_LB;
        default: return ctrl_pkg::ST_EXC_NOOPCODE;
    endcase
endfunction

// One clock edge of the reference sequence
function automatic void model_step(logic [5:0] op, logic [5:0] fn, logic ov_in);
    ctrl_pkg::ctrl_state_t nxt;
    nxt = ctrl_pkg::ST_FETCH_WAIT;
    case (model_state)
        ctrl_pkg::ST_FETCH_WAIT: begin
            nxt = (model_cycles + 1 == ctrl_pkg::FETCH_WAIT_CYCLES) ?
                  ctrl_pkg::ST_FETCH : ctrl_pkg::ST_FETCH_WAIT;
        end
        ctrl_pkg::ST_FETCH:    nxt = ctrl_pkg::ST_DECODE;
        ctrl_pkg::ST_DECODE:   nxt = ctrl_pkg::ST_DISPATCH;
        ctrl_pkg::ST_DISPATCH: nxt = execute_state(op, fn);
        ctrl_pkg::ST_ADD:      nxt = ov_in ? ctrl_pkg::ST_EXC_OVERFLOW : ctrl_pkg::ST_WB_R;
        ctrl_pkg::ST_SUB:      nxt = ov_in ? ctrl_pkg::ST_EXC_OVERFLOW : ctrl_pkg::ST_WB_R;
        ctrl_pkg::ST_ADDI:     nxt = ov_in ? ctrl_pkg::ST_EXC_OVERFLOW : ctrl_pkg::ST_WB_I;
        ctrl_pkg::ST_AND:      nxt = ctrl_pkg::ST_WB_R;
        ctrl_pkg::ST_ADDIU:    nxt = ctrl_pkg::ST_WB_I;
        ctrl_pkg::ST_EXC_NOOPCODE, ctrl_pkg::ST_EXC_OVERFLOW: begin
            nxt = (model_cycles + 1 == ctrl_pkg::EXC_WAIT_CYCLES) ?
                  ctrl_pkg::ST_EXC_COMMIT : model_state;
        end
        default: nxt = ctrl_pkg::ST_FETCH_WAIT;
    endcase

    if (nxt != model_state) begin
        case (nxt)
            ctrl_pkg::ST_WB_R, ctrl_pkg::ST_WB_I:               alu_count++;
            ctrl_pkg::ST_LW, ctrl_pkg::ST_LH, ctrl_pkg::ST_LB:  load_count++;
            ctrl_pkg::ST_EXC_OVERFLOW:                          ovf_count++;
            ctrl_pkg::ST_EXC_NOOPCODE:                          illegal_count++;
            default: ;
        endcase
    end
    model_cycles = (nxt == model_state) ? model_cycles + 1 : 0;
    model_state  = nxt;
endfunction

function automatic ctrl_pkg::ctrl_strobes_t expected_strobes(ctrl_pkg::ctrl_state_t st);
    ctrl_pkg::ctrl_strobes_t s;
    s = '0;
    case (st)
        ctrl_pkg::ST_FETCH: begin
            s.pc_write = 1'b1;
            s.ir_write = 1'b1;
        end
        ctrl_pkg::ST_DECODE: begin
            s.a_write = 1'b1;
            s.b_write = 1'b1;
        end
        ctrl_pkg::ST_ADD, ctrl_pkg::ST_AND, ctrl_pkg::ST_SUB,
        ctrl_pkg::ST_ADDI, ctrl_pkg::ST_ADDIU: s.alu_out_write = 1'b1;
        ctrl_pkg::ST_WB_R, ctrl_pkg::ST_WB_I,
        ctrl_pkg::ST_LW, ctrl_pkg::ST_LH, ctrl_pkg::ST_LB: s.reg_write = 1'b1;
        ctrl_pkg::ST_EXC_COMMIT: begin
            s.epc_write = 1'b1;
            s.pc_write  = 1'b1;
        end
        default: ;
    endcase
    return s;
endfunction

function automatic ctrl_pkg::ctrl_selects_t expected_selects(ctrl_pkg::ctrl_state_t st);
    ctrl_pkg::ctrl_selects_t s;
    s = '0;
    case (st)
        ctrl_pkg::ST_FETCH_WAIT, ctrl_pkg::ST_FETCH, ctrl_pkg::ST_DECODE: begin
            s.alu_src_b = ctrl_pkg::SRC_B_FOUR;
            s.alu_op    = ctrl_pkg::ALU_ADD;
            if (st == ctrl_pkg::ST_FETCH) begin
                s.iord = ctrl_pkg::ADDR_FETCH;
            end
        end
        ctrl_pkg::ST_ADD, ctrl_pkg::ST_AND, ctrl_pkg::ST_SUB: begin
            s.alu_src_a = ctrl_pkg::SRC_A_REG;
            s.alu_src_b = ctrl_pkg::SRC_B_REG;
            s.alu_op    = (st == ctrl_pkg::ST_ADD) ? ctrl_pkg::ALU_ADD :
                          (st == ctrl_pkg::ST_AND) ? ctrl_pkg::ALU_AND : ctrl_pkg::ALU_SUB;
        end
        ctrl_pkg::ST_ADDI, ctrl_pkg::ST_ADDIU: begin
            s.alu_src_a = ctrl_pkg::SRC_A_REG;
            s.alu_src_b = ctrl_pkg::SRC_B_IMM;
            s.alu_op    = ctrl_pkg::ALU_ADD;
        end
        ctrl_pkg::ST_WB_R: s.reg_dst = ctrl_pkg::DST_RD;
        ctrl_pkg::ST_LW, ctrl_pkg::ST_LH, ctrl_pkg::ST_LB: begin
            s.mem_to_reg = ctrl_pkg::WB_MDR;
            s.load_width = (st == ctrl_pkg::ST_LW) ? ctrl_pkg::LOAD_WORD :
                           (st == ctrl_pkg::ST_LH) ? ctrl_pkg::LOAD_HALF : ctrl_pkg::LOAD_BYTE;
        end
        ctrl_pkg::ST_EXC_NOOPCODE, ctrl_pkg::ST_EXC_OVERFLOW: begin
            s.except_cause = (st == ctrl_pkg::ST_EXC_OVERFLOW) ?
                             ctrl_pkg::CAUSE_OVERFLOW : ctrl_pkg::CAUSE_NOOPCODE;
            s.iord         = ctrl_pkg::ADDR_EXC;
            s.alu_src_b    = ctrl_pkg::SRC_B_FOUR;
            s.alu_op       = ctrl_pkg::ALU_AND;
        end
        ctrl_pkg::ST_EXC_COMMIT: s.pc_src = ctrl_pkg::PC_EXC_VECTOR;
        default: ;
    endcase
    return s;
endfunction

`endif

// ==== dv/tb_mips_control.sv ====
`timescale 1ns/1ps

module tb_mips_control;

    localparam int RUN_CYCLES    = 3000;
    localparam int RESET_CYCLES  = 4;
    localparam int FETCH_TIMEOUT = 20;

    localparam ctrl_pkg::ctrl_strobes_t FETCH_STROBES =
        '{pc_write: 1'b1, ir_write: 1'b1, default: 1'b0};
    localparam ctrl_pkg::ctrl_strobes_t DECODE_STROBES =
        '{a_write: 1'b1, b_write: 1'b1, default: 1'b0};

    logic       clk;
    logic       reset;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       ov;
    logic       pc_write, ir_write, a_write, b_write;
    logic       alu_out_write, reg_write, epc_write;
    logic [1:0] alu_src_a;
    logic [2:0] alu_src_b;
    logic [2:0] alu_op;
    logic [2:0] iord;
    logic [2:0] pc_src;
    logic [1:0] reg_dst;
    logic [3:0] mem_to_reg;
    logic [1:0] load_width;
    logic [1:0] except_cause;

    int seed = 35154;
    int error_count;
    int check_count;
    int cycle_count;
    bit timed_out;

    `include "control_model.svh"

    mips_control u_mips_control (.*);

    always #10 clk = ~clk;

    function automatic ctrl_pkg::ctrl_strobes_t dut_strobes();
        return ctrl_pkg::ctrl_strobes_t'({pc_write, ir_write, a_write, b_write,
                                          alu_out_write, reg_write, epc_write});
    endfunction

    function automatic ctrl_pkg::ctrl_selects_t dut_selects();
        return ctrl_pkg::ctrl_selects_t'({alu_src_a, alu_src_b, alu_op, iord, pc_src,
                                          reg_dst, mem_to_reg, load_width, except_cause});
    endfunction

    task automatic check_field(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %0t ns: %s expected %0d, got %0d (model state %s)",
                     $time, name, exp, act, model_state.name());
        end
    endtask

    task automatic compare_strobes(input ctrl_pkg::ctrl_strobes_t e,
                                   input ctrl_pkg::ctrl_strobes_t a);
        check_count++;
        check_field("pc_write", 4'(e.pc_write), 4'(a.pc_write));
        check_field("ir_write", 4'(e.ir_write), 4'(a.ir_write));
        check_field("a_write", 4'(e.a_write), 4'(a.a_write));
        check_field("b_write", 4'(e.b_write), 4'(a.b_write));
        check_field("alu_out_write", 4'(e.alu_out_write), 4'(a.alu_out_write));
        check_field("reg_write", 4'(e.reg_write), 4'(a.reg_write));
        check_field("epc_write", 4'(e.epc_write), 4'(a.epc_write));
    endtask

    task automatic compare_selects(input ctrl_pkg::ctrl_selects_t e,
                                   input ctrl_pkg::ctrl_selects_t a);
        check_count++;
        check_field("alu_src_a", 4'(e.alu_src_a), 4'(a.alu_src_a));
        check_field("alu_src_b", 4'(e.alu_src_b), 4'(a.alu_src_b));
        check_field("alu_op", 4'(e.alu_op), 4'(a.alu_op));
        check_field("iord", 4'(e.iord), 4'(a.iord));
        check_field("pc_src", 4'(e.pc_src), 4'(a.pc_src));
        check_field("reg_dst", 4'(e.reg_dst), 4'(a.reg_dst));
        check_field("mem_to_reg", 4'(e.mem_to_reg), 4'(a.mem_to_reg));
        check_field("load_width", 4'(e.load_width), 4'(a.load_width));
        check_field("except_cause", 4'(e.except_cause), 4'(a.except_cause));
    endtask

    // About one draw in six is illegal, by opcode or by function code
    task automatic drive_inputs();
        logic [31:0] rnd;
        int unsigned pick;
        rnd  = $random(seed);
        pick = rnd % 12;
        rnd  = $random(seed);
        ov   = (rnd[1:0] == 2'b00);
        rnd  = $random(seed);
        opcode = rnd[5:0];
        funct  = rnd[11:6];
        case (pick)
            0, 1:    {opcode, funct} = {6'h00, 6'h20};
            2:       {opcode, funct} = {6'h00, 6'h24};
            3, 4:    {opcode, funct} = {6'h00, 6'h22};
            5:       opcode = 6'h08;
            6:       opcode = 6'h09;
            7:       opcode = 6'h23;
            8:       opcode = 6'h21;
            9:       opcode = 6'h20;
            10: begin
                // Flipping bit 4 moves every kept opcode off the map
                if (opcode inside {6'h00, 6'h08, 6'h09, 6'h20, 6'h21, 6'h23}) begin
                    opcode = opcode ^ 6'h10;
                end
            end
            default: begin
                opcode = 6'h00;
                if (funct inside {6'h20, 6'h22, 6'h24}) begin
                    funct = funct ^ 6'h01;
                end
            end
        endcase
    endtask

    task automatic run_cycle();
        @(posedge clk);
        model_step(opcode, funct, ov);
        #1;
        drive_inputs();
        @(negedge clk);
        compare_strobes(expected_strobes(model_state), dut_strobes());
        compare_selects(expected_selects(model_state), dut_selects());
        cycle_count++;
    endtask

    task automatic check_first_fetch();
        int idle;
        int waited;
        idle   = 0;
        waited = 0;
        while (!(pc_write && ir_write) && waited < FETCH_TIMEOUT) begin
            if (dut_strobes() == '0) begin
                idle++;
            end
            run_cycle();
            waited++;
        end
        if (waited >= FETCH_TIMEOUT) begin
            timed_out = 1'b1;
            $display("Timed out after %0d cycles waiting for the first fetch after reset",
                     waited);
        end else begin
            if (idle != ctrl_pkg::FETCH_WAIT_CYCLES) begin
                error_count++;
                $display("[ERROR] %0t ns: %0d quiet cycles before the first fetch, expected %0d",
                         $time, idle, ctrl_pkg::FETCH_WAIT_CYCLES);
            end
            compare_strobes(FETCH_STROBES, dut_strobes());
            run_cycle();
            compare_strobes(DECODE_STROBES, dut_strobes());
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        opcode      = '0;
        funct       = '0;
        ov          = 1'b0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        timed_out   = 1'b0;
        model_reset();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        drive_inputs();
        @(negedge clk);
        compare_strobes(expected_strobes(model_state), dut_strobes());
        compare_selects(expected_selects(model_state), dut_selects());

        check_first_fetch();
        while (!timed_out && cycle_count < RUN_CYCLES) begin
            run_cycle();
        end

        if (!timed_out && (alu_count == 0 || load_count == 0 || ovf_count == 0 ||
                           illegal_count == 0)) begin
            error_count++;
            $display("Some instruction kinds were never exercised by the random stimulus");
        end

        $display("Checks %0d, errors %0d, timeouts %0d, alu %0d, loads %0d, ov traps %0d, %s %0d",
                 check_count, error_count, timed_out, alu_count, load_count, ovf_count,
                 "illegal traps", illegal_count);
        if (error_count == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== hdl/ctrl_pkg.sv ====
package ctrl_pkg;

    // Wait counts, in clock cycles
    localparam int FETCH_WAIT_CYCLES = 3;
    localparam int EXC_WAIT_CYCLES   = 8;
    localparam int WAIT_CNT_W        = 4;

    // Primary opcodes that the unit executes
    typedef enum logic [5:0] {
        R_TYPE = 6'h00,
        ADDI   = 6'h08,
        ADDIU  = 6'h09,
        LB     = 6'h20,
        LH     = 6'h21,
        LW     = 6'h23
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24
    } funct_t;

    typedef enum logic [3:0] {
        CLS_ADD,
        CLS_AND,
        CLS_SUB,
        CLS_ADDI,
        CLS_ADDIU,
        CLS_LW,
        CLS_LH,
        CLS_LB,
        CLS_ILLEGAL
    } instr_class_t;

    typedef enum logic [4:0] {
        ST_FETCH_WAIT,
        ST_FETCH,
        ST_DECODE,
        ST_DISPATCH,
        ST_ADD,
        ST_AND,
        ST_SUB,
        ST_ADDI,
        ST_ADDIU,
        ST_WB_R,
        ST_WB_I,
        ST_LW,
        ST_LH,
        ST_LB,
        ST_EXC_NOOPCODE,
        ST_EXC_OVERFLOW,
        ST_EXC_COMMIT
    } ctrl_state_t;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_SUB  = 3'd3
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_A_PC  = 2'd0,
        SRC_A_REG = 2'd1
    } alu_src_a_t;

    typedef enum logic [2:0] {
        SRC_B_REG  = 3'd0,
        SRC_B_FOUR = 3'd1,
        SRC_B_IMM  = 3'd2
    } alu_src_b_t;

    // Memory address select
    typedef enum logic [2:0] {
        ADDR_PC    = 3'd0,
        ADDR_FETCH = 3'd1,
        ADDR_EXC   = 3'd2
    } iord_t;

    typedef enum logic [2:0] {
        PC_ALU        = 3'd0,
        PC_EXC_VECTOR = 3'd3
    } pc_src_t;

    typedef enum logic [1:0] {
        DST_RT = 2'd0,
        DST_RD = 2'd1
    } reg_dst_t;

    typedef enum logic [3:0] {
        WB_ALU = 4'd0,
        WB_MDR = 4'd1
    } mem_to_reg_t;

    typedef enum logic [1:0] {
        LOAD_WORD = 2'd0,
        LOAD_HALF = 2'd1,
        LOAD_BYTE = 2'd2
    } load_width_t;

    typedef enum logic [1:0] {
        CAUSE_NOOPCODE = 2'd0,
        CAUSE_OVERFLOW = 2'd1
    } except_cause_t;

    typedef struct packed {
        logic pc_write;
        logic ir_write;
        logic a_write;
        logic b_write;
        logic alu_out_write;
        logic reg_write;
        logic epc_write;
    } ctrl_strobes_t;

    typedef struct packed {
        alu_src_a_t    alu_src_a;
        alu_src_b_t    alu_src_b;
        alu_op_t       alu_op;
        iord_t         iord;
        pc_src_t       pc_src;
        reg_dst_t      reg_dst;
        mem_to_reg_t   mem_to_reg;
        load_width_t   load_width;
        except_cause_t except_cause;
    } ctrl_selects_t;

endpackage

// ==== hdl/ctrl_sequencer.sv ====
`timescale 1ns/1ps

module ctrl_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  ctrl_pkg::instr_class_t instr_class,
    input  logic                   ov,
    output ctrl_pkg::ctrl_state_t  state
);

    ctrl_pkg::ctrl_state_t         next_state;
    logic [ctrl_pkg::WAIT_CNT_W-1:0] wait_cnt;
    logic [ctrl_pkg::WAIT_CNT_W-1:0] next_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ctrl_pkg::ST_FETCH_WAIT;
            wait_cnt <= '0;
        end else begin
            state    <= next_state;
            wait_cnt <= next_cnt;
        end
    end

    always_comb begin
        next_state = state;
        // Counter is zero on every exit, so each wait starts from zero
        next_cnt   = '0;

        case (state)
            ctrl_pkg::ST_FETCH_WAIT: begin
                if (int'(wait_cnt) == ctrl_pkg::FETCH_WAIT_CYCLES - 1) begin
                    next_state = ctrl_pkg::ST_FETCH;
                end else begin
                    next_cnt = wait_cnt + 1'b1;
                end
            end
            ctrl_pkg::ST_FETCH: begin
                next_state = ctrl_pkg::ST_DECODE;
            end
            ctrl_pkg::ST_DECODE: begin
                next_state = ctrl_pkg::ST_DISPATCH;
            end
            ctrl_pkg::ST_DISPATCH: begin
                case (instr_class)
                    ctrl_pkg::CLS_ADD:   next_state = ctrl_pkg::ST_ADD;
                    ctrl_pkg::CLS_AND:   next_state = ctrl_pkg::ST_AND;
                    ctrl_pkg::CLS_SUB:   next_state = ctrl_pkg::ST_SUB;
                    ctrl_pkg::CLS_ADDI:  next_state = ctrl_pkg::ST_ADDI;
                    ctrl_pkg::CLS_ADDIU: next_state = ctrl_pkg::ST_ADDIU;
                    ctrl_pkg::CLS_LW:    next_state = ctrl_pkg::ST_LW;
                    ctrl_pkg::CLS_LH:    next_state = ctrl_pkg::ST_LH;
                    ctrl_pkg::CLS_LB:    next_state = ctrl_pkg::ST_LB;
                    default:             next_state = ctrl_pkg::ST_EXC_NOOPCODE;
                endcase
            end
            // Signed ops trap on overflow at the end of execute
            ctrl_pkg::ST_ADD, ctrl_pkg::ST_SUB: begin
                next_state = ov ? ctrl_pkg::ST_EXC_OVERFLOW : ctrl_pkg::ST_WB_R;
            end
            ctrl_pkg::ST_ADDI: begin
                next_state = ov ? ctrl_pkg::ST_EXC_OVERFLOW : ctrl_pkg::ST_WB_I;
            end
            ctrl_pkg::ST_AND: begin
                next_state = ctrl_pkg::ST_WB_R;
            end
            ctrl_pkg::ST_ADDIU: begin
                next_state = ctrl_pkg::ST_WB_I;
            end
            ctrl_pkg::ST_WB_R, ctrl_pkg::ST_WB_I,
            ctrl_pkg::ST_LW, ctrl_pkg::ST_LH, ctrl_pkg::ST_LB: begin
                next_state = ctrl_pkg::ST_FETCH_WAIT;
            end
            ctrl_pkg::ST_EXC_NOOPCODE, ctrl_pkg::ST_EXC_OVERFLOW: begin
                if (int'(wait_cnt) == ctrl_pkg::EXC_WAIT_CYCLES - 1) begin
                    next_state = ctrl_pkg::ST_EXC_COMMIT;
                end else begin
                    next_cnt = wait_cnt + 1'b1;
                end
            end
            ctrl_pkg::ST_EXC_COMMIT: begin
                next_state = ctrl_pkg::ST_FETCH_WAIT;
            end
            default: begin
                next_state = ctrl_pkg::ST_FETCH_WAIT;
            end
        endcase
    end

endmodule

// ==== hdl/ctrl_word_encoder.sv ====
`timescale 1ns/1ps

module ctrl_word_encoder (
    input  ctrl_pkg::ctrl_state_t state,
    datapath_ctrl_if.source       ctrl
);

    ctrl_pkg::ctrl_strobes_t strobes;
    ctrl_pkg::ctrl_selects_t selects;

    always_comb begin
        // All fields start at their zero value in every state
        strobes              = '0;
        selects.alu_src_a    = ctrl_pkg::SRC_A_PC;
        selects.alu_src_b    = ctrl_pkg::SRC_B_REG;
        selects.alu_op       = ctrl_pkg::ALU_PASS;
        selects.iord         = ctrl_pkg::ADDR_PC;
        selects.pc_src       = ctrl_pkg::PC_ALU;
        selects.reg_dst      = ctrl_pkg::DST_RT;
        selects.mem_to_reg   = ctrl_pkg::WB_ALU;
        selects.load_width   = ctrl_pkg::LOAD_WORD;
        selects.except_cause = ctrl_pkg::CAUSE_NOOPCODE;

        case (state)
            ctrl_pkg::ST_FETCH_WAIT: begin
                selects.alu_src_b = ctrl_pkg::SRC_B_FOUR;
                selects.alu_op    = ctrl_pkg::ALU_ADD;
                selects.iord      = ctrl_pkg::ADDR_PC;
            end
            // PC + 4 and instruction register load together
            ctrl_pkg::ST_FETCH: begin
                strobes.pc_write  = 1'b1;
                strobes.ir_write  = 1'b1;
                selects.iord      = ctrl_pkg::ADDR_FETCH;
                selects.alu_src_b = ctrl_pkg::SRC_B_FOUR;
                selects.alu_op    = ctrl_pkg::ALU_ADD;
            end
            ctrl_pkg::ST_DECODE: begin
                strobes.a_write   = 1'b1;
                strobes.b_write   = 1'b1;
                selects.alu_src_b = ctrl_pkg::SRC_B_FOUR;
                selects.alu_op    = ctrl_pkg::ALU_ADD;
            end
            ctrl_pkg::ST_ADD, ctrl_pkg::ST_AND, ctrl_pkg::ST_SUB: begin
                strobes.alu_out_write = 1'b1;
                selects.alu_src_a     = ctrl_pkg::SRC_A_REG;
                selects.alu_src_b     = ctrl_pkg::SRC_B_REG;
                case (state)
                    ctrl_pkg::ST_AND: selects.alu_op = ctrl_pkg::ALU_AND;
                    ctrl_pkg::ST_SUB: selects.alu_op = ctrl_pkg::ALU_SUB;
                    default:          selects.alu_op = ctrl_pkg::ALU_ADD;
                endcase
            end
            ctrl_pkg::ST_ADDI, ctrl_pkg::ST_ADDIU: begin
                strobes.alu_out_write = 1'b1;
                selects.alu_src_a     = ctrl_pkg::SRC_A_REG;
                selects.alu_src_b     = ctrl_pkg::SRC_B_IMM;
                selects.alu_op        = ctrl_pkg::ALU_ADD;
            end
            ctrl_pkg::ST_WB_R: begin
                strobes.reg_write = 1'b1;
                selects.reg_dst   = ctrl_pkg::DST_RD;
            end
            ctrl_pkg::ST_WB_I: begin
                strobes.reg_write = 1'b1;
                selects.reg_dst   = ctrl_pkg::DST_RT;
            end
            // Load data comes from MDR, trimmed by the width code
            ctrl_pkg::ST_LW, ctrl_pkg::ST_LH, ctrl_pkg::ST_LB: begin
                strobes.reg_write  = 1'b1;
                selects.reg_dst    = ctrl_pkg::DST_RT;
                selects.mem_to_reg = ctrl_pkg::WB_MDR;
                case (state)
                    ctrl_pkg::ST_LH: selects.load_width = ctrl_pkg::LOAD_HALF;
                    ctrl_pkg::ST_LB: selects.load_width = ctrl_pkg::LOAD_BYTE;
                    default:         selects.load_width = ctrl_pkg::LOAD_WORD;
                endcase
            end
            ctrl_pkg::ST_EXC_NOOPCODE, ctrl_pkg::ST_EXC_OVERFLOW: begin
                selects.except_cause = (state == ctrl_pkg::ST_EXC_OVERFLOW) ?
                                       ctrl_pkg::CAUSE_OVERFLOW : ctrl_pkg::CAUSE_NOOPCODE;
                selects.iord         = ctrl_pkg::ADDR_EXC;
                selects.alu_src_b    = ctrl_pkg::SRC_B_FOUR;
                selects.alu_op       = ctrl_pkg::ALU_AND;
            end
            // Save the faulting PC and jump to the handler
            ctrl_pkg::ST_EXC_COMMIT: begin
                strobes.epc_write = 1'b1;
                strobes.pc_write  = 1'b1;
                selects.pc_src    = ctrl_pkg::PC_EXC_VECTOR;
            end
            default: begin
            end
        endcase
    end

    assign ctrl.strobes = strobes;
    assign ctrl.selects = selects;

endmodule

// ==== hdl/datapath_ctrl_if.sv ====
`timescale 1ns/1ps

// Control fields from the state encoder toward the datapath
interface datapath_ctrl_if;

    // Write enables of PC, IR, A, B, ALUOut, register file and EPC
    ctrl_pkg::ctrl_strobes_t strobes;

    // Multiplexer selects, ALU operation, load width and cause
    ctrl_pkg::ctrl_selects_t selects;

    modport source (
        output strobes,
        output selects
    );

    modport sink (
        input strobes,
        input selects
    );

endinterface

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  ctrl_pkg::opcode_t      opcode,
    input  ctrl_pkg::funct_t       funct,
    output ctrl_pkg::instr_class_t instr_class
);

    always_comb begin
        case (opcode)
            ctrl_pkg::R_TYPE: begin
                // Function field selects the ALU operation
                case (funct)
                    ctrl_pkg::ADD: begin
                        instr_class = ctrl_pkg::CLS_ADD;
                    end
                    ctrl_pkg::AND: begin
                        instr_class = ctrl_pkg::CLS_AND;
                    end
                    ctrl_pkg::SUB: begin
                        instr_class = ctrl_pkg::CLS_SUB;
                    end
                    default: begin
                        instr_class = ctrl_pkg::CLS_ILLEGAL;
                    end
                endcase
            end
            ctrl_pkg::ADDI: begin
                instr_class = ctrl_pkg::CLS_ADDI;
            end
            ctrl_pkg::ADDIU: begin
                instr_class = ctrl_pkg::CLS_ADDIU;
            end
            ctrl_pkg::LW: begin
                instr_class = ctrl_pkg::CLS_LW;
            end
            ctrl_pkg::LH: begin
                instr_class = ctrl_pkg::CLS_LH;
            end
            ctrl_pkg::LB: begin
                instr_class = ctrl_pkg::CLS_LB;
            end
            // Branches, jumps, stores and the rest trap
            default: begin
                instr_class = ctrl_pkg::CLS_ILLEGAL;
            end
        endcase
    end

endmodule

// ==== hdl/mips_control.sv ====
`timescale 1ns/1ps

module mips_control (
    input  logic       clk,
    input  logic       reset,
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    input  logic       ov,
    output logic       pc_write,
    output logic       ir_write,
    output logic       a_write,
    output logic       b_write,
    output logic       alu_out_write,
    output logic       reg_write,
    output logic       epc_write,
    output logic [1:0] alu_src_a,
    output logic [2:0] alu_src_b,
    output logic [2:0] alu_op,
    output logic [2:0] iord,
    output logic [2:0] pc_src,
    output logic [1:0] reg_dst,
    output logic [3:0] mem_to_reg,
    output logic [1:0] load_width,
    output logic [1:0] except_cause
);

    ctrl_pkg::instr_class_t instr_class;
    ctrl_pkg::ctrl_state_t  state;

    datapath_ctrl_if u_ctrl_if ();

    instr_decoder u_instr_decoder (
        .opcode      (ctrl_pkg::opcode_t'(opcode)),
        .funct       (ctrl_pkg::funct_t'(funct)),
        .instr_class (instr_class)
    );

    ctrl_sequencer u_ctrl_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .ov          (ov),
        .state       (state)
    );

    ctrl_word_encoder u_ctrl_word_encoder (
        .state (state),
        .ctrl  (u_ctrl_if.source)
    );

    // Write enables
    assign pc_write      = u_ctrl_if.strobes.pc_write;
    assign ir_write      = u_ctrl_if.strobes.ir_write;
    assign a_write       = u_ctrl_if.strobes.a_write;
    assign b_write       = u_ctrl_if.strobes.b_write;
    assign alu_out_write = u_ctrl_if.strobes.alu_out_write;
    assign reg_write     = u_ctrl_if.strobes.reg_write;
    assign epc_write     = u_ctrl_if.strobes.epc_write;

    // Selects
    assign alu_src_a     = u_ctrl_if.selects.alu_src_a;
    assign alu_src_b     = u_ctrl_if.selects.alu_src_b;
    assign alu_op        = u_ctrl_if.selects.alu_op;
    assign iord          = u_ctrl_if.selects.iord;
    assign pc_src        = u_ctrl_if.selects.pc_src;
    assign reg_dst       = u_ctrl_if.selects.reg_dst;
    assign mem_to_reg    = u_ctrl_if.selects.mem_to_reg;
    assign load_width    = u_ctrl_if.selects.load_width;
    assign except_cause  = u_ctrl_if.selects.except_cause;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_mips_control -Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_mips_control" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Finished with no errors" "$log_file"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $log_file"
exit 1

// ==== src.f ====
+incdir+dv
hdl/ctrl_pkg.sv
hdl/datapath_ctrl_if.sv
hdl/instr_decoder.sv
hdl/ctrl_sequencer.sv
hdl/ctrl_word_encoder.sv
hdl/mips_control.sv
dv/mips_control_properties.sv
dv/tb_mips_control.sv
